// File: src.f
hdl/eth_hdr_pkg.sv
hdl/av_stream_pkg.sv
hdl/sample_fifo.sv
hdl/crc32_gen.sv
hdl/ip_checksum.sv
hdl/udp_frame_tx.sv
hdl/av_udp_tx_top.sv
verification/tb_av_udp_tx.sv

// File: Bender.yml
package:
  name: av_udp_tx

sources:
  # Packages first
  - hdl/eth_hdr_pkg.sv
  - hdl/av_stream_pkg.sv
  # Leaf modules
  - hdl/sample_fifo.sv
  - hdl/crc32_gen.sv
  - hdl/ip_checksum.sv
  - hdl/udp_frame_tx.sv
  # Top level
  - hdl/av_udp_tx_top.sv
  # Testbench
  - target: test
    files:
      - verification/tb_av_udp_tx.sv

// File: verification/tb_av_udp_tx.sv
`timescale 1ns/1ps

module tb_av_udp_tx;

	localparam int CLK_HALF         = 20;
	// Audio packets held by a full audio FIFO
	localparam int AUD_BURST_FRAMES = av_stream_pkg::AUD_FIFO_DEPTH
		/ av_stream_pkg::AUD_WORDS_PER_PKT;
	// Frames sent over the whole run
	localparam int NUM_FRAMES       = 7 + AUD_BURST_FRAMES;
	// Longest frame plus its gap
	localparam int FRAME_SLOT       = 133;
	// Write phases and reset fit easily in the margin
	localparam int WATCHDOG_CYC     = NUM_FRAMES * FRAME_SLOT + 600;
	// First payload byte after preamble 8 and headers 42
	localparam int PAY_POS          = 50;

	// DUT ports
	logic                       fifo_clk;
	logic                       sys_rst;
	logic                       node_id;
	logic                       rgb_mode;
	logic                       pix_wr;
	av_stream_pkg::pixel_word_u pix_data;
	logic                       pix_full;
	logic                       aud_wr;
	av_stream_pkg::audio_word_t aud_data;
	logic                       aud_full;
	eth_hdr_pkg::gmii_tx_t      gmii;

	// Reference model words in acceptance order
	av_stream_pkg::pixel_word_u pix_ref [$];
	av_stream_pkg::audio_word_t aud_ref [$];
	logic [15:0] exp_line = '0;
	logic [7:0]  exp_seq  = '0;

	// FIFO occupancy model and pops due at the coming edge
	int         pix_cnt      = 0;
	int         aud_cnt      = 0;
	bit         pix_pop      = 1'b0;
	bit         aud_pop      = 1'b0;

	// Frame capture
	logic [7:0] cur_bytes [$];
	logic [7:0] frame_bytes [$];
	bit         in_frame     = 1'b0;
	// Quiet cycles since the last frame or -1 before the first one
	int         low_run      = -1;
	int         cur_gap      = -1;
	int         frame_gap    = -1;
	int         frames_seen  = 0;
	int         frames_taken = 0;

	// Counters
	string       cur_test;
	int          check_cnt     = 0;
	int          err_cnt       = 0;
	int          test_chk_base = 0;
	int          test_err_base = 0;
	int          tests_run     = 0;
	int          tests_failed  = 0;
	logic [31:0] lfsr_state;

	av_udp_tx_top dut (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.node_id  (node_id),
		.rgb_mode (rgb_mode),
		.pix_wr   (pix_wr),
		.pix_data (pix_data),
		.pix_full (pix_full),
		.aud_wr   (aud_wr),
		.aud_data (aud_data),
		.aud_full (aud_full),
		.gmii     (gmii)
	);

	initial begin
		fifo_clk = 1'b0;
		forever begin
			#(CLK_HALF) fifo_clk = ~fifo_clk;
		end
	end

	// Run limit
	initial begin
		repeat (WATCHDOG_CYC) @(posedge fifo_clk);
		$display("Watchdog expired after %0d cycles with %0d of %0d frames seen",
			WATCHDOG_CYC, frames_seen, NUM_FRAMES);
		$display("TEST FAIL");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Monitors
	// ------------------------------------------------------------------------
	// Wire bytes taken mid-cycle and the FIFO model stepped for the coming edge
	always @(negedge fifo_clk) begin
		if (sys_rst) begin
			in_frame = 1'b0;
			low_run  = -1;
			pix_cnt  = 0;
			aud_cnt  = 0;
		end else begin
			pix_pop = 1'b0;
			aud_pop = 1'b0;
			if (gmii.tx_en) begin
				if (!in_frame) begin
					in_frame = 1'b1;
					cur_bytes.delete();
					cur_gap = low_run;
				end
				cur_bytes.push_back(gmii.txd);
				pix_pop = pops_word(1'b1);
				aud_pop = pops_word(1'b0);
			end else begin
				if (in_frame) begin
					// Falling tx_en closes the frame
					in_frame    = 1'b0;
					frame_bytes = cur_bytes;
					frame_gap   = cur_gap;
					frames_seen++;
					low_run = 1;
				end else if (low_run >= 0) begin
					low_run++;
				end
			end
			track_fifos();
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	// Right-shift Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] galois_step(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = galois_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Pop due at the coming edge for the byte just captured
	function automatic bit pops_word(bit video);
		int idx;
		int first;
		int words;
		idx = cur_bytes.size() - 1;
		if (idx <= PAY_POS) begin
			return 1'b0;
		end
		if ((cur_bytes[PAY_POS] == av_stream_pkg::PKT_VIDEO) != video) begin
			return 1'b0;
		end
		// Samples follow the kind byte and a 2-byte line or 1-byte sequence
		first = PAY_POS + (video ? 3 : 2);
		words = video ? av_stream_pkg::PIX_WORDS_PER_PKT : av_stream_pkg::AUD_WORDS_PER_PKT;
		// Second byte of each word
		return (idx > first) && (idx < first + 2 * words) && ((idx - first) % 2 == 1);
	endfunction

	// Big-endian field from the last captured frame
	function automatic logic [63:0] get_field(int pos, int n);
		logic [63:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[55:0], frame_bytes[pos + i]};
		end
		return v;
	endfunction

	// One's-complement sum of 16-bit words
	function automatic logic [15:0] ones_fold(int pos, int n);
		logic [31:0] acc;
		int          i;
		acc = '0;
		for (i = 0; i < n; i += 2) begin
			acc = acc + {16'd0, frame_bytes[pos + i], frame_bytes[pos + i + 1]};
		end
		while (acc[31:16] != 16'd0) begin
			acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
		end
		return acc[15:0];
	endfunction

	// Bit-serial Ethernet CRC over data LSB first with the result complemented
	function automatic logic [31:0] eth_crc(int pos, int n);
		logic [31:0] c;
		logic        fb;
		int          i;
		int          b;
		c = 32'hffff_ffff;
		for (i = 0; i < n; i++) begin
			for (b = 0; b < 8; b++) begin
				fb = c[0] ^ frame_bytes[pos + i][b];
				c  = c >> 1;
				if (fb) begin
					c = c ^ eth_hdr_pkg::CRC32_POLY;
				end
			end
		end
		return ~c;
	endfunction

	task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
		check_cnt++;
		assert (act === exp) else begin
			$display("FAILED %s %s: expected %0h actual %0h", cur_test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_true(bit cond, string msg);
		check_cnt++;
		assert (cond) else begin
			$display("%s: %s", cur_test, msg);
			err_cnt++;
		end
	endtask

	// Full flags against the model, then writes and pops of the coming edge
	task automatic track_fifos();
		check_value("pix_full", pix_cnt == av_stream_pkg::PIX_FIFO_DEPTH, pix_full);
		check_value("aud_full", aud_cnt == av_stream_pkg::AUD_FIFO_DEPTH, aud_full);
		// A full FIFO drops the write
		if (pix_wr && (pix_cnt < av_stream_pkg::PIX_FIFO_DEPTH)) begin
			pix_ref.push_back(pix_data);
			pix_cnt++;
		end
		if (aud_wr && (aud_cnt < av_stream_pkg::AUD_FIFO_DEPTH)) begin
			aud_ref.push_back(aud_data);
			aud_cnt++;
		end
		if (pix_pop) begin
			pix_cnt--;
		end
		if (aud_pop) begin
			aud_cnt--;
		end
	endtask

	task automatic test_begin(string name);
		cur_test      = name;
		test_chk_base = check_cnt;
		test_err_base = err_cnt;
	endtask

	task automatic test_finish();
		int errs;
		errs = err_cnt - test_err_base;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("%s: %0d checks, %0d errors", cur_test, check_cnt - test_chk_base, errs);
	endtask

	// Levels held until the frame that uses them has started
	task automatic set_levels(bit node, bit rgb);
		@(posedge fifo_clk);
		node_id  <= node;
		rgb_mode <= rgb;
	endtask

	// Both streams written in parallel, one word per cycle each
	task automatic drive_words(int n_pix, int n_aud);
		int i;
		int n;
		n = (n_pix > n_aud) ? n_pix : n_aud;
		for (i = 0; i < n; i++) begin
			@(posedge fifo_clk);
			pix_wr <= (i < n_pix);
			aud_wr <= (i < n_aud);
			if (i < n_pix) begin
				pix_data <= 24'(take_bits(24));
			end
			if (i < n_aud) begin
				aud_data <= 16'(take_bits(16));
			end
		end
		@(posedge fifo_clk);
		pix_wr <= 1'b0;
		aud_wr <= 1'b0;
	endtask

	task automatic next_frame();
		frames_taken++;
		wait (frames_seen >= frames_taken);
	endtask

	// ------------------------------------------------------------------------
	// Frame check against the reference model
	// ------------------------------------------------------------------------
	task automatic check_frame(bit video, bit node, bit rgb, int exp_gap);
		int                         pay_len;
		int                         fcs;
		int                         i;
		logic [47:0]                exp_mac;
		logic [31:0]                exp_ip;
		logic [15:0]                exp_pair;
		av_stream_pkg::pixel_word_u pw;

		pay_len = video ? av_stream_pkg::VIDEO_PAYLOAD_BYTES
			: av_stream_pkg::AUDIO_PAYLOAD_BYTES;
		// Preamble 8 + headers 42
		fcs = 50 + pay_len;
		check_value("frame length", video ? 121 : 72, frame_bytes.size());
		if (frame_bytes.size() != (video ? 121 : 72)) begin
			return;
		end
		if (exp_gap >= 0) begin
			check_value("inter-frame gap", exp_gap, frame_gap);
		end
		for (i = 0; i < 7; i++) begin
			check_value($sformatf("preamble byte %0d", i), 8'h55, frame_bytes[i]);
		end
		check_value("sfd", 8'hd5, frame_bytes[7]);

		// Ethernet
		exp_mac = eth_hdr_pkg::DST_MAC;
		exp_mac[7:0] = exp_mac[7:0] - {7'd0, node};
		check_value("destination mac", exp_mac, get_field(8, 6));
		exp_mac = eth_hdr_pkg::SRC_MAC;
		exp_mac[7:0] = exp_mac[7:0] + {7'd0, node};
		check_value("source mac", exp_mac, get_field(14, 6));
		check_value("ethertype", eth_hdr_pkg::ETH_TYPE_IPV4, get_field(20, 2));

		// IPv4
		check_value("ip version and tos", eth_hdr_pkg::IP_VER_TOS, get_field(22, 2));
		check_value("ip total length", 28 + pay_len, get_field(24, 2));
		check_value("ip ident", eth_hdr_pkg::IP_IDENT, get_field(26, 2));
		check_value("ip flags", eth_hdr_pkg::IP_FLAGS, get_field(28, 2));
		check_value("ip ttl", eth_hdr_pkg::IP_TTL, get_field(30, 1));
		check_value("ip protocol", eth_hdr_pkg::IP_PROTO_UDP, get_field(31, 1));
		// Whole header with its checksum sums to all ones
		check_value("ip header checksum fold", 16'hffff, ones_fold(22, 20));
		exp_ip = eth_hdr_pkg::IP_SRC_ADDR;
		exp_ip[7:0] = exp_ip[7:0] + {7'd0, node};
		check_value("source ip", exp_ip, get_field(34, 4));
		exp_ip = eth_hdr_pkg::IP_DST_ADDR;
		exp_ip[7:0] = exp_ip[7:0] - {7'd0, node};
		check_value("destination ip", exp_ip, get_field(38, 4));

		// UDP header with its checksum sent as zero
		check_value("udp source port", eth_hdr_pkg::UDP_SRC_PORT, get_field(42, 2));
		check_value("udp destination port", eth_hdr_pkg::UDP_DST_PORT, get_field(44, 2));
		check_value("udp length", pay_len + 8, get_field(46, 2));
		check_value("udp checksum", 16'h0000, get_field(48, 2));

		// Payload
		if (video) begin
			check_value("kind byte", av_stream_pkg::PKT_VIDEO, get_field(50, 1));
			check_value("line number", exp_line, get_field(51, 2));
			exp_line = exp_line + 16'd1;
			for (i = 0; i < av_stream_pkg::PIX_WORDS_PER_PKT; i++) begin
				if (pix_ref.size() == 0) begin
					check_true(1'b0, "reference pixel queue ran empty");
					return;
				end
				pw = pix_ref.pop_front();
				// Y then chroma, or green then red
				exp_pair = rgb ? {pw.rgb.g, pw.rgb.r} : {pw.yuv.y, pw.yuv.c};
				check_value($sformatf("pixel word %0d", i), exp_pair, get_field(53 + 2 * i, 2));
			end
		end else begin
			check_value("kind byte", av_stream_pkg::PKT_AUDIO, get_field(50, 1));
			check_value("audio sequence", exp_seq, get_field(51, 1));
			exp_seq = exp_seq + 8'd1;
			for (i = 0; i < av_stream_pkg::AUD_WORDS_PER_PKT; i++) begin
				if (aud_ref.size() == 0) begin
					check_true(1'b0, "reference audio queue ran empty");
					return;
				end
				// High byte first
				check_value($sformatf("audio sample %0d", i), aud_ref.pop_front(),
					get_field(52 + 2 * i, 2));
			end
		end

		// FCS low byte first on the wire
		check_value("fcs", eth_crc(8, fcs - 8),
			{frame_bytes[fcs + 3], frame_bytes[fcs + 2], frame_bytes[fcs + 1], frame_bytes[fcs]});
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		int k;
		sys_rst    = 1'b1;
		node_id    = 1'b0;
		rgb_mode   = 1'b0;
		pix_wr     = 1'b0;
		pix_data   = '0;
		aud_wr     = 1'b0;
		aud_data   = '0;
		lfsr_state = 32'h84b6_f48c;

		// Quiet line in and after reset with nothing buffered
		test_begin("reset");
		@(posedge fifo_clk);
		@(negedge fifo_clk);
		check_value("tx_en in reset", 1'b0, gmii.tx_en);
		check_value("txd in reset", 8'h00, gmii.txd);
		@(posedge fifo_clk);
		sys_rst <= 1'b0;
		repeat (16) begin
			@(negedge fifo_clk);
			check_true(!gmii.tx_en && (gmii.txd == 8'h00),
				"a frame started although both FIFOs are empty");
		end
		test_finish();

		test_begin("video_yuv");
		set_levels(1'b0, 1'b0);
		drive_words(av_stream_pkg::PIX_WORDS_PER_PKT, 0);
		next_frame();
		check_frame(1'b1, 1'b0, 1'b0, -1);
		test_finish();

		test_begin("audio");
		set_levels(1'b1, 1'b0);
		drive_words(0, av_stream_pkg::AUD_WORDS_PER_PKT);
		next_frame();
		check_frame(1'b0, 1'b1, 1'b0, -1);
		test_finish();

		test_begin("video_rgb");
		set_levels(1'b1, 1'b1);
		drive_words(av_stream_pkg::PIX_WORDS_PER_PKT, 0);
		next_frame();
		check_frame(1'b1, 1'b1, 1'b1, -1);
		test_finish();

		// Last pixel and last sample land on the same edge
		test_begin("priority");
		set_levels(1'b0, 1'b0);
		drive_words(av_stream_pkg::PIX_WORDS_PER_PKT - 1, 0);
		drive_words(0, av_stream_pkg::AUD_WORDS_PER_PKT - 1);
		drive_words(1, 1);
		next_frame();
		check_frame(1'b1, 1'b0, 1'b0, -1);
		next_frame();
		check_frame(1'b0, 1'b0, 1'b0, eth_hdr_pkg::IFG_CYCLES);
		test_finish();

		// Two packets fill the pixel FIFO and the two words after them are dropped
		test_begin("back_to_back");
		set_levels(1'b1, 1'b0);
		drive_words(2 * av_stream_pkg::PIX_WORDS_PER_PKT + 2, 0);
		next_frame();
		check_frame(1'b1, 1'b1, 1'b0, -1);
		next_frame();
		check_frame(1'b1, 1'b1, 1'b0, eth_hdr_pkg::IFG_CYCLES);
		test_finish();

		// Audio FIFO written past its depth drains as packets separated by the gap
		test_begin("audio_overflow");
		set_levels(1'b0, 1'b0);
		drive_words(0, av_stream_pkg::AUD_FIFO_DEPTH + 2);
		for (k = 0; k < AUD_BURST_FRAMES; k++) begin
			next_frame();
			check_frame(1'b0, 1'b0, 1'b0, (k == 0) ? -1 : eth_hdr_pkg::IFG_CYCLES);
		end
		test_finish();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: hdl/av_udp_tx_top.sv
`timescale 1ns/1ps

module av_udp_tx_top (
	input  logic                       fifo_clk,
	input  logic                       sys_rst,
	input  logic                       node_id,
	input  logic                       rgb_mode,
	input  logic                       pix_wr,
	input  av_stream_pkg::pixel_word_u pix_data,
	output logic                       pix_full,
	input  logic                       aud_wr,
	input  av_stream_pkg::audio_word_t aud_data,
	output logic                       aud_full,
	output eth_hdr_pkg::gmii_tx_t      gmii
);

	// FIFO heads and fill levels
	av_stream_pkg::pixel_word_u                     pix_head;
	logic [$clog2(av_stream_pkg::PIX_FIFO_DEPTH):0] pix_level;
	logic                                           pix_rd;
	av_stream_pkg::audio_word_t                     aud_head;
	logic [$clog2(av_stream_pkg::AUD_FIFO_DEPTH):0] aud_level;
	logic                                           aud_rd;

	// Checksum and CRC handshakes
	logic        csum_start;
	logic [15:0] total_len;
	logic [15:0] hdr_csum;
	logic        crc_init;
	logic        crc_en;
	logic [1:0]  crc_byte_sel;
	logic [7:0]  fcs_byte;

	// ------------------------------------------------------------------------
	// Sample buffers
	// ------------------------------------------------------------------------
	sample_fifo #(
		.WIDTH ($bits(av_stream_pkg::pixel_word_u)),
		.DEPTH (av_stream_pkg::PIX_FIFO_DEPTH)
	) u_pix_fifo (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr       (pix_wr),
		.wr_data  (pix_data),
		.full     (pix_full),
		.rd       (pix_rd),
		.rd_data  (pix_head),
		.level    (pix_level)
	);

	sample_fifo #(
		.WIDTH ($bits(av_stream_pkg::audio_word_t)),
		.DEPTH (av_stream_pkg::AUD_FIFO_DEPTH)
	) u_aud_fifo (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr       (aud_wr),
		.wr_data  (aud_data),
		.full     (aud_full),
		.rd       (aud_rd),
		.rd_data  (aud_head),
		.level    (aud_level)
	);

	// ------------------------------------------------------------------------
	// Framing
	// ------------------------------------------------------------------------
	udp_frame_tx u_frame_tx (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.node_id      (node_id),
		.rgb_mode     (rgb_mode),
		.pix_word     (pix_head),
		.pix_level    (pix_level),
		.pix_rd       (pix_rd),
		.aud_word     (aud_head),
		.aud_level    (aud_level),
		.aud_rd       (aud_rd),
		.csum_start   (csum_start),
		.total_len    (total_len),
		.hdr_csum     (hdr_csum),
		.crc_init     (crc_init),
		.crc_en       (crc_en),
		.crc_byte_sel (crc_byte_sel),
		.fcs_byte     (fcs_byte),
		.gmii         (gmii)
	);

	// Sampled on the same cycle as the sequencer's node copy
	ip_checksum u_ip_checksum (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.start     (csum_start),
		.total_len (total_len),
		.node_id   (node_id),
		.hdr_csum  (hdr_csum)
	);

	// Fed straight from the wire byte
	crc32_gen u_crc32 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc_init (crc_init),
		.crc_en   (crc_en),
		.data     (gmii.txd),
		.byte_sel (crc_byte_sel),
		.fcs_byte (fcs_byte)
	);

endmodule

// File: hdl/udp_frame_tx.sv
`timescale 1ns/1ps

module udp_frame_tx (
	input  logic                                        fifo_clk,
	input  logic                                        sys_rst,
	input  logic                                        node_id,
	input  logic                                        rgb_mode,
	input  av_stream_pkg::pixel_word_u                  pix_word,
	input  logic [$clog2(av_stream_pkg::PIX_FIFO_DEPTH):0] pix_level,
	output logic                                        pix_rd,
	input  av_stream_pkg::audio_word_t                  aud_word,
	input  logic [$clog2(av_stream_pkg::AUD_FIFO_DEPTH):0] aud_level,
	output logic                                        aud_rd,
	output logic                                        csum_start,
	output logic [15:0]                                 total_len,
	input  logic [15:0]                                 hdr_csum,
	output logic                                        crc_init,
	output logic                                        crc_en,
	output logic [1:0]                                  crc_byte_sel,
	input  logic [7:0]                                  fcs_byte,
	output eth_hdr_pkg::gmii_tx_t                       gmii
);

	// State names what is on the wire in this cycle
	typedef enum logic [2:0] {
		IDLE,
		PRE,
		SFD,
		HDR,
		PAYLOAD,
		FCS,
		IFG
	} state_t;

	state_t      state;
	// Byte counter within the current state
	logic [7:0]  cnt;
	logic        is_video;
	logic [6:0]  pay_len;
	// Frame copies of the level inputs
	logic        node_q;
	logic        rgb_q;
	logic [15:0] line_num;
	logic [7:0]  aud_seq;

	logic        vid_rdy;
	logic        aud_rdy;
	logic [15:0] udp_len;
	logic [7:0]  dst_mac_lo;
	logic [7:0]  src_mac_lo;
	logic [7:0]  src_ip_lo;
	logic [7:0]  dst_ip_lo;
	logic [8*eth_hdr_pkg::HDR_BYTES-1:0] hdr_vec;
	logic [7:0]  hdr_byte;
	// Offsets into the sample area of the payload
	logic [7:0]  vid_off;
	logic [7:0]  aud_off;
	logic [7:0]  pay_byte;

	// Whole packet already buffered
	assign vid_rdy = (pix_level >= av_stream_pkg::PIX_WORDS_PER_PKT);
	assign aud_rdy = (aud_level >= av_stream_pkg::AUD_WORDS_PER_PKT);

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= IDLE;
			cnt      <= '0;
			is_video <= 1'b0;
			pay_len  <= '0;
			node_q   <= 1'b0;
			rgb_q    <= 1'b0;
			line_num <= '0;
			aud_seq  <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Video wins a tie
					if (vid_rdy || aud_rdy) begin
						state    <= PRE;
						cnt      <= '0;
						is_video <= vid_rdy;
						pay_len  <= vid_rdy ? 7'(av_stream_pkg::VIDEO_PAYLOAD_BYTES)
							: 7'(av_stream_pkg::AUDIO_PAYLOAD_BYTES);
					end
				end
				PRE: begin
					// Latched with the checksum start
					if (cnt == 8'd0) begin
						node_q <= node_id;
						rgb_q  <= rgb_mode;
					end
					if (cnt == 8'(eth_hdr_pkg::PREAMBLE_LEN - 1)) begin
						state <= SFD;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				SFD: begin
					state <= HDR;
					cnt   <= '0;
				end
				HDR: begin
					if (cnt == 8'(eth_hdr_pkg::HDR_BYTES - 1)) begin
						state <= PAYLOAD;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				PAYLOAD: begin
					if (cnt == {1'b0, pay_len} - 8'd1) begin
						state <= FCS;
						cnt   <= '0;
						// Numbering advances once the frame carried it
						if (is_video) begin
							line_num <= line_num + 16'd1;
						end else begin
							aud_seq <= aud_seq + 8'd1;
						end
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				FCS: begin
					if (cnt == 8'(eth_hdr_pkg::FCS_BYTES - 1)) begin
						state <= IFG;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				IFG: begin
					// IDLE supplies the last quiet cycle of the gap
					if (cnt == 8'(eth_hdr_pkg::IFG_CYCLES - 2)) begin
						state <= IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				default: begin
					state <= IDLE;
					cnt   <= '0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Length fields and side units
	// ------------------------------------------------------------------------
	assign total_len = 16'(eth_hdr_pkg::IP_HDR_BYTES + eth_hdr_pkg::UDP_HDR_BYTES)
		+ {9'd0, pay_len};
	assign udp_len   = 16'(eth_hdr_pkg::UDP_HDR_BYTES) + {9'd0, pay_len};

	// First preamble cycle
	assign csum_start   = (state == PRE) && (cnt == 8'd0);
	assign crc_init     = (state == SFD);
	// CRC covers the header and payload bytes as sent
	assign crc_en       = (state == HDR) || (state == PAYLOAD);
	assign crc_byte_sel = cnt[1:0];

	// Node identity on the last address bytes
	assign dst_mac_lo = eth_hdr_pkg::DST_MAC[7:0] - {7'd0, node_q};
	assign src_mac_lo = eth_hdr_pkg::SRC_MAC[7:0] + {7'd0, node_q};
	assign src_ip_lo  = eth_hdr_pkg::IP_SRC_ADDR[7:0] + {7'd0, node_q};
	assign dst_ip_lo  = eth_hdr_pkg::IP_DST_ADDR[7:0] - {7'd0, node_q};

	// Header in wire order, first byte at the top, UDP checksum left zero
	assign hdr_vec = {
		eth_hdr_pkg::DST_MAC[47:8], dst_mac_lo,
		eth_hdr_pkg::SRC_MAC[47:8], src_mac_lo,
		eth_hdr_pkg::ETH_TYPE_IPV4,
		eth_hdr_pkg::IP_VER_TOS, total_len,
		eth_hdr_pkg::IP_IDENT, eth_hdr_pkg::IP_FLAGS,
		eth_hdr_pkg::IP_TTL, eth_hdr_pkg::IP_PROTO_UDP, hdr_csum,
		eth_hdr_pkg::IP_SRC_ADDR[31:8], src_ip_lo,
		eth_hdr_pkg::IP_DST_ADDR[31:8], dst_ip_lo,
		eth_hdr_pkg::UDP_SRC_PORT, eth_hdr_pkg::UDP_DST_PORT,
		udp_len, 16'h0000
	};
	assign hdr_byte = hdr_vec[($bits(hdr_vec) - 8) - 8 * cnt +: 8];

	// ------------------------------------------------------------------------
	// Payload bytes and FIFO pops
	// ------------------------------------------------------------------------
	assign vid_off = cnt - 8'(av_stream_pkg::VIDEO_PREFIX_BYTES);
	assign aud_off = cnt - 8'(av_stream_pkg::AUDIO_PREFIX_BYTES);

	always_comb begin
		if (is_video) begin
			case (cnt)
				8'd0: pay_byte = av_stream_pkg::PKT_VIDEO;
				8'd1: pay_byte = line_num[15:8];
				8'd2: pay_byte = line_num[7:0];
				default: begin
					// Y then chroma, or green then red
					if (vid_off[0]) begin
						pay_byte = rgb_q ? pix_word.rgb.r : pix_word.yuv.c;
					end else begin
						pay_byte = rgb_q ? pix_word.rgb.g : pix_word.yuv.y;
					end
				end
			endcase
		end else begin
			case (cnt)
				8'd0:    pay_byte = av_stream_pkg::PKT_AUDIO;
				8'd1:    pay_byte = aud_seq;
				// Sample high byte first
				default: pay_byte = aud_off[0] ? aud_word[7:0] : aud_word[15:8];
			endcase
		end
	end

	// Pop on the second byte of a word
	assign pix_rd = (state == PAYLOAD) && is_video && (pix_level != '0)
		&& (cnt >= 8'(av_stream_pkg::VIDEO_PREFIX_BYTES)) && vid_off[0];
	assign aud_rd = (state == PAYLOAD) && !is_video && (aud_level != '0)
		&& (cnt >= 8'(av_stream_pkg::AUDIO_PREFIX_BYTES)) && aud_off[0];

	// GMII byte mux
	always_comb begin
		case (state)
			PRE: begin
				gmii.tx_en = 1'b1;
				gmii.txd   = eth_hdr_pkg::PREAMBLE_BYTE;
			end
			SFD: begin
				gmii.tx_en = 1'b1;
				gmii.txd   = eth_hdr_pkg::SFD_BYTE;
			end
			HDR: begin
				gmii.tx_en = 1'b1;
				gmii.txd   = hdr_byte;
			end
			PAYLOAD: begin
				gmii.tx_en = 1'b1;
				gmii.txd   = pay_byte;
			end
			FCS: begin
				gmii.tx_en = 1'b1;
				gmii.txd   = fcs_byte;
			end
			// Quiet line in IDLE and IFG
			default: begin
				gmii.tx_en = 1'b0;
				gmii.txd   = 8'h00;
			end
		endcase
	end

endmodule

// File: hdl/ip_checksum.sv
`timescale 1ns/1ps

module ip_checksum (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        start,
	input  logic [15:0] total_len,
	input  logic        node_id,
	output logic [15:0] hdr_csum
);

	// Low address bytes shifted by node identity
	logic [7:0]  src_lo;
	logic [7:0]  dst_lo;
	// Nine 16-bit words fit in 20 bits
	logic [19:0] word_sum;
	logic [16:0] fold1;
	logic [15:0] fold2;

	assign src_lo = eth_hdr_pkg::IP_SRC_ADDR[7:0] + {7'd0, node_id};
	assign dst_lo = eth_hdr_pkg::IP_DST_ADDR[7:0] - {7'd0, node_id};

	// Checksum field itself counts as zero
	always_comb begin
		word_sum = {4'd0, eth_hdr_pkg::IP_VER_TOS}
			+ {4'd0, total_len}
			+ {4'd0, eth_hdr_pkg::IP_IDENT}
			+ {4'd0, eth_hdr_pkg::IP_FLAGS}
			+ {4'd0, eth_hdr_pkg::IP_TTL, eth_hdr_pkg::IP_PROTO_UDP}
			+ {4'd0, eth_hdr_pkg::IP_SRC_ADDR[31:16]}
			+ {4'd0, eth_hdr_pkg::IP_SRC_ADDR[15:8], src_lo}
			+ {4'd0, eth_hdr_pkg::IP_DST_ADDR[31:16]}
			+ {4'd0, eth_hdr_pkg::IP_DST_ADDR[15:8], dst_lo};
		// End-around carry, twice is enough for 20 bits
		fold1 = {1'b0, word_sum[15:0]} + {13'd0, word_sum[19:16]};
		fold2 = fold1[15:0] + {15'd0, fold1[16]};
	end

	// Held until the next frame
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			hdr_csum <= '0;
		end else if (start) begin
			hdr_csum <= ~fold2;
		end
	end

endmodule

// File: hdl/crc32_gen.sv
`timescale 1ns/1ps

module crc32_gen (
	input  logic       fifo_clk,
	input  logic       sys_rst,
	input  logic       crc_init,
	input  logic       crc_en,
	input  logic [7:0] data,
	input  logic [1:0] byte_sel,
	output logic [7:0] fcs_byte
);

	logic [31:0] crc_q;
	logic [31:0] fcs_word;

	// One byte through the reflected LFSR, LSB first
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			if (r[0]) begin
				r = (r >> 1) ^ eth_hdr_pkg::CRC32_POLY;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// Accumulator
	// ------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= '1;
		end else if (crc_init) begin
			// Preset, no byte taken in this cycle
			crc_q <= '1;
		end else if (crc_en) begin
			crc_q <= crc_step(crc_q, data);
		end
	end

	// Complemented remainder is the FCS
	assign fcs_word = ~crc_q;

	// Low byte goes out first
	always_comb begin
		case (byte_sel)
			2'd0:    fcs_byte = fcs_word[7:0];
			2'd1:    fcs_byte = fcs_word[15:8];
			2'd2:    fcs_byte = fcs_word[23:16];
			default: fcs_byte = fcs_word[31:24];
		endcase
	end

endmodule

// File: hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
	parameter int WIDTH = 24,
	parameter int DEPTH = 64
) (
	input  logic                    fifo_clk,
	input  logic                    sys_rst,
	input  logic                    wr,
	input  logic [WIDTH-1:0]        wr_data,
	output logic                    full,
	input  logic                    rd,
	output logic [WIDTH-1:0]        rd_data,
	output logic [$clog2(DEPTH):0]  level
);

	// Storage, power of two depth so pointers wrap by themselves
	logic [WIDTH-1:0] mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	// Qualified strobes
	logic wr_ok;
	logic rd_ok;

	assign full  = (level == DEPTH);
	// Write while full is dropped
	assign wr_ok = wr & ~full;
	// Pop only with something inside
	assign rd_ok = rd & (level != '0);

	// Head entry, seen without a read latency
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge fifo_clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------------------------------------------------
	// Pointers and occupancy
	// ------------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous read and write leaves level alone
			case ({wr_ok, rd_ok})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

// File: hdl/av_stream_pkg.sv
package av_stream_pkg;

	// Pixel word in YUV order, spare byte unused on the wire
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] c;
		logic [7:0] spare;
	} yuv_word_t;

	// Same word read as RGB
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_word_t;

	// Decoded per frame by rgb_mode
	typedef union packed {
		yuv_word_t yuv;
		rgb_word_t rgb;
	} pixel_word_u;

	typedef logic [15:0] audio_word_t;

	// Kind byte, first payload byte
	localparam logic [7:0] PKT_VIDEO = 8'd0;
	localparam logic [7:0] PKT_AUDIO = 8'd1;

	// ------------------------------------------------------------------------
	// Payload sizes
	// ------------------------------------------------------------------------
	localparam int PIX_WORDS_PER_PKT   = 32;
	localparam int AUD_WORDS_PER_PKT   = 8;
	// Kind + line number
	localparam int VIDEO_PREFIX_BYTES  = 3;
	// Kind + sequence
	localparam int AUDIO_PREFIX_BYTES  = 2;
	localparam int VIDEO_PAYLOAD_BYTES = 67;
	localparam int AUDIO_PAYLOAD_BYTES = 18;

	localparam int PIX_FIFO_DEPTH = 64;
	localparam int AUD_FIFO_DEPTH = 32;

endpackage

// File: hdl/eth_hdr_pkg.sv
package eth_hdr_pkg;

	// ------------------------------------------------------------------------
	// Addresses for node 0
	// ------------------------------------------------------------------------
	// node_id is subtracted from the destination low byte
	// and added to the source low byte
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam logic [31:0] IP_SRC_ADDR  = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] IP_DST_ADDR  = {8'd192, 8'd168, 8'd0, 8'd2};

	// Fixed header fields
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	// Version 4, IHL 5, TOS 0
	localparam logic [15:0] IP_VER_TOS    = 16'h4500;
	localparam logic [15:0] IP_IDENT      = 16'h0000;
	// Don't fragment
	localparam logic [15:0] IP_FLAGS      = 16'h4000;
	localparam logic [7:0]  IP_TTL        = 8'h40;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	localparam logic [15:0] UDP_SRC_PORT  = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT  = 16'h3039;

	// ------------------------------------------------------------------------
	// Frame layout
	// ------------------------------------------------------------------------
	localparam int PREAMBLE_LEN  = 7;
	// Ethernet 14 + IPv4 20 + UDP 8
	localparam int HDR_BYTES     = 42;
	localparam int IP_HDR_BYTES  = 20;
	localparam int UDP_HDR_BYTES = 8;
	localparam int FCS_BYTES     = 4;
	localparam int IFG_CYCLES    = 12;

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hd5;

	// Reflected Ethernet polynomial
	localparam logic [31:0] CRC32_POLY = 32'hedb8_8320;

	// GMII transmit side, one byte per clock
	typedef struct packed {
		logic       tx_en;
		logic [7:0] txd;
	} gmii_tx_t;

endpackage
